/* icache.f */
icache_pkg.sv
icache_cfg.sv
icache_ctrl.sv
icache_arrays.sv
icache_repl.sv
icache_refill.sv
icache_top.sv
tb_icache_mem.sv
tb_icache.sv

/* icache_arrays.sv */
//////////////////////////////////////////////////
// icache arrays: per-way tag, valid and data store
// with tag compare and word select
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module icache_arrays #(
  parameter int unsigned NumWays = 4,
  parameter int unsigned NumSets = 64
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_ni,
  input  wire logic                                 rd_i,
  input  wire logic                                 wr_i,
  input  wire logic [$clog2(NumSets)-1:0]           index_i,
  input  wire logic [icache_pkg::ADDR_W-$clog2(NumSets)-icache_pkg::OFFSET_W-1:0] tag_i,
  input  wire icache_pkg::line_t                    wr_line_i,
  input  wire logic [NumWays-1:0]                   wr_way_i,
  input  wire logic [$clog2(icache_pkg::LINE_WORDS)-1:0] offset_i,
  input  wire logic                                 clear_i,
  input  wire logic [$clog2(NumSets)-1:0]           clear_idx_i,
  output logic                                      hit_o,
  output icache_pkg::word_t                         hit_word_o,
  output logic [NumWays-1:0]                        valid_o
);

  import icache_pkg::*;

  localparam int unsigned IdxW = $clog2(NumSets);
  localparam int unsigned TagW = ADDR_W - IdxW - OFFSET_W;
  localparam int unsigned WayW = $clog2(NumWays);
  localparam int unsigned WoffW = $clog2(LINE_WORDS);

  typedef logic [TagW-1:0]    tag_t;
  typedef logic [NumWays-1:0] way_t;
  typedef logic [WayW-1:0]    way_idx_t;
  typedef logic [WoffW-1:0]   woff_t;

  // storage
  tag_t  tag_mem   [NumWays][NumSets];
  line_t data_mem  [NumWays][NumSets];
  way_t  valid_mem [NumSets];

  // read stage
  tag_t     rd_tag_q  [NumWays];
  line_t    rd_line_q [NumWays];
  way_t     rd_valid_q;
  tag_t     cmp_tag_q;
  woff_t    off_q;

  way_t     hit_way;
  way_idx_t hit_idx;

  //////////////////////////////////////////////////
  // writes and clears
  //////////////////////////////////////////////////

  // clear and refill write never overlap, the clear only runs when idle
  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      valid_mem[clear_idx_i] <= '0;
    end else if (wr_i) begin
      valid_mem[index_i] <= valid_mem[index_i] | wr_way_i;
    end
    for (int w = 0; w < NumWays; w++) begin
      if (wr_i && wr_way_i[w]) begin
        tag_mem[w][index_i]  <= tag_i;
        data_mem[w][index_i] <= wr_line_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // registered read
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      for (int w = 0; w < NumWays; w++) begin
        rd_tag_q[w]  <= tag_mem[w][index_i];
        rd_line_q[w] <= data_mem[w][index_i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= '0;
      cmp_tag_q  <= '0;
      off_q      <= '0;
    end else if (rd_i) begin
      rd_valid_q <= valid_mem[index_i];
      // the tag is compared one cycle later
      cmp_tag_q  <= tag_i;
      off_q      <= offset_i;
    end
  end

  // compare each way against the latched tag
  for (genvar w = 0; w < NumWays; w++) begin : gen_cmp
    assign hit_way[w] = rd_valid_q[w] & (rd_tag_q[w] == cmp_tag_q);
  end

  // encode the hit way, lowest way wins
  always_comb begin
    hit_idx = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (hit_way[w]) begin
        hit_idx = way_idx_t'(w);
      end
    end
  end

  assign hit_o      = |hit_way;
  assign hit_word_o = rd_line_q[hit_idx][off_q*WORD_W +: WORD_W];
  // valid bits of the set just read, for victim choice
  assign valid_o    = rd_valid_q;

endmodule

`default_nettype wire

/* icache_cfg.sv */
//////////////////////////////////////////////////
// icache config: enable state and flush sequencer
// that clears every valid bit one set per cycle
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module icache_cfg #(
  parameter int unsigned NumSets = 64
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       en_i,
  input  wire logic                       flush_i,
  input  wire logic                       ctrl_idle_i,
  output logic                            cache_en_o,
  output logic                            hold_o,
  output logic                            clear_o,
  output logic [$clog2(NumSets)-1:0]      clear_idx_o
);

  localparam int unsigned IdxW = $clog2(NumSets);

  typedef logic [IdxW-1:0] idx_t;

  logic cache_en_q;
  logic en_prev_q;
  // flush requested but not yet started
  logic pend_q;
  logic clearing_q;
  idx_t cnt_q;

  logic en_rise;
  logic start;
  logic last;

  // enabling a disabled cache has to go through a clear
  // a pending or running clear already samples en_i at its end
  assign en_rise = en_i & ~en_prev_q & ~cache_en_q & ~pend_q & ~clearing_q;

  // clear waits for the controller to drain
  assign start = pend_q & ctrl_idle_i & ~clearing_q;
  assign last  = clearing_q & (cnt_q == idx_t'(NumSets - 1));

  // dropping en_i switches the cache off in the same cycle
  assign cache_en_o  = cache_en_q & en_i;
  // hold goes up as soon as a request shows up
  assign hold_o      = pend_q | clearing_q | flush_i | en_rise;
  assign clear_o     = clearing_q;
  assign clear_idx_o = cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cache_en_q <= 1'b0;
      en_prev_q  <= 1'b0;
      // come out of reset with a clear queued
      pend_q     <= 1'b1;
      clearing_q <= 1'b0;
      cnt_q      <= '0;
    end else begin
      en_prev_q <= en_i;
      // new requests win over the start of a clear
      pend_q    <= (pend_q & ~start) | flush_i | en_rise;

      if (start) begin
        clearing_q <= 1'b1;
        cnt_q      <= '0;
      end else if (clearing_q) begin
        // counter wraps back to zero after the last set
        cnt_q <= cnt_q + 1'b1;
        if (last) begin
          clearing_q <= 1'b0;
        end
      end

      // enable state is only loaded at the end of a clear
      if (last) begin
        cache_en_q <= en_i;
      end else begin
        cache_en_q <= cache_en_q & en_i;
      end
    end
  end

endmodule

`default_nettype wire

/* icache_ctrl.sv */
//////////////////////////////////////////////////
// icache controller: lookup/miss FSM, fetch port
// handshake and array / refill sequencing
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
  parameter int unsigned NumWays = 4,
  parameter int unsigned NumSets = 64
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // fetch port
  input  wire icache_pkg::fetch_req_t fetch_req_i,
  output logic                        fetch_ready_o,
  output icache_pkg::fetch_rsp_t      fetch_rsp_o,
  // config
  input  wire logic                   cache_en_i,
  input  wire logic                   hold_i,
  output logic                        idle_o,
  // arrays
  output logic                        rd_o,
  output logic                        wr_o,
  output logic [$clog2(NumSets)-1:0]  index_o,
  output logic [icache_pkg::ADDR_W-$clog2(NumSets)-icache_pkg::OFFSET_W-1:0] tag_o,
  output icache_pkg::line_t           wr_line_o,
  input  wire logic                   hit_i,
  input  wire icache_pkg::word_t      hit_word_i,
  input  wire logic [NumWays-1:0]     victim_i,
  output logic [NumWays-1:0]          wr_way_o,
  // refill
  output logic                        refill_start_o,
  output icache_pkg::addr_t           refill_addr_o,
  output logic                        refill_single_o,
  input  wire logic                   refill_done_i,
  input  wire icache_pkg::line_t      refill_line_i
);

  import icache_pkg::*;

  localparam int unsigned IdxW = $clog2(NumSets);
  localparam int unsigned TagW = ADDR_W - IdxW - OFFSET_W;

  typedef logic [NumWays-1:0] way_t;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // address of the request in flight
  addr_t addr_q;
  way_t  victim_q;
  // current miss bypasses the arrays
  logic  nc_q;

  addr_t sel_addr;
  word_t fill_word;

  //////////////////////////////////////////////////
  // address plumbing
  //////////////////////////////////////////////////

  // lookups use the incoming address, writes the latched one
  assign sel_addr = rd_o ? fetch_req_i.addr : addr_q;
  assign index_o  = sel_addr[OFFSET_W +: IdxW];
  assign tag_o    = sel_addr[ADDR_W-1 -: TagW];

  // line base for a refill, word address when the cache is off
  assign refill_single_o = ~cache_en_i;
  assign refill_addr_o   = cache_en_i ? {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}} :
                                        {addr_q[ADDR_W-1:2], 2'b00};

  // refill buffer stays stable until the next start
  assign fill_word = refill_line_i[addr_q[OFFSET_W-1:2]*WORD_W +: WORD_W];
  assign wr_line_o = refill_line_i;
  assign wr_way_o  = victim_q;
  assign idle_o    = (state_q == IDLE);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d           = state_q;
    fetch_ready_o     = 1'b0;
    fetch_rsp_o.valid = 1'b0;
    fetch_rsp_o.data  = hit_word_i;
    rd_o              = 1'b0;
    wr_o              = 1'b0;
    refill_start_o    = 1'b0;

    unique case (state_q)
      IDLE: begin
        fetch_ready_o = ~hold_i;
        if (fetch_req_i.req && !hold_i) begin
          rd_o    = 1'b1;
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (cache_en_i && hit_i) begin
          fetch_rsp_o.valid = 1'b1;
          // back-to-back hits, one per cycle
          fetch_ready_o     = ~hold_i;
          if (fetch_req_i.req && !hold_i) begin
            rd_o = 1'b1;
          end else begin
            state_d = IDLE;
          end
        end else begin
          // miss, or a non-cacheable read while disabled
          refill_start_o = 1'b1;
          state_d        = REFILL;
        end
      end
      REFILL: begin
        if (refill_done_i) begin
          state_d = FILL_WAIT;
        end
      end
      FILL_WAIT: begin
        fetch_rsp_o.valid = 1'b1;
        fetch_rsp_o.data  = fill_word;
        // nothing is allocated in disabled mode
        wr_o              = ~nc_q;
        state_d           = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      nc_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (refill_start_o) begin
        nc_q <= refill_single_o;
      end
    end
  end

  // victim comes from the valid bits read in LOOKUP
  always_ff @(posedge clk_i) begin
    if (rd_o) begin
      addr_q <= fetch_req_i.addr;
    end
    if (refill_start_o) begin
      victim_q <= victim_i;
    end
  end

endmodule

`default_nettype wire

/* icache_pkg.sv */
//////////////////////////////////////////////////
// icache shared types: widths, bus structs and the
// controller state encoding
//////////////////////////////////////////////////
`default_nettype none

package icache_pkg;

  // byte address and fetch word widths
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned WORD_W     = 32;

  // four words per line, so 16 bytes of offset
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned OFFSET_W   = 4;

  typedef logic [ADDR_W-1:0]            addr_t;
  typedef logic [WORD_W-1:0]            word_t;
  // word 0 of a line sits in the low bits
  typedef logic [LINE_WORDS*WORD_W-1:0] line_t;

  // fetch unit request, lower two address bits are ignored
  typedef struct packed {
    logic  req;
    addr_t addr;
  } fetch_req_t;

  // one-cycle response, no back-pressure
  typedef struct packed {
    logic  valid;
    word_t data;
  } fetch_rsp_t;

  // wishbone classic master outputs (read only)
  typedef struct packed {
    logic  cyc;
    logic  stb;
    addr_t adr;
  } wb_req_t;

  // wishbone classic slave outputs
  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

  // lookup / miss FSM
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    REFILL,
    FILL_WAIT
  } ctrl_state_e;

endpackage

`default_nettype wire

/* icache_refill.sv */
//////////////////////////////////////////////////
// icache refill: wishbone classic read master for
// a four-beat line or a single word
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module icache_refill (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               start_i,
  input  wire icache_pkg::addr_t  addr_i,
  input  wire logic               single_i,
  output logic                    done_o,
  output icache_pkg::line_t       line_o,
  output icache_pkg::wb_req_t     wb_o,
  input  wire icache_pkg::wb_rsp_t wb_i
);

  import icache_pkg::*;

  localparam int unsigned BeatW  = $clog2(LINE_WORDS);
  localparam int unsigned LINE_W = LINE_WORDS * WORD_W;

  typedef logic [BeatW-1:0] beat_t;

  logic  cyc_q;
  logic  stb_q;
  logic  single_q;
  logic  done_q;
  beat_t beat_q;
  addr_t adr_q;
  // line buffer, held until the next start
  line_t line_q;

  logic  beat_ack;
  logic  last_ack;

  assign beat_ack = stb_q & wb_i.ack;
  assign last_ack = beat_ack & (single_q | (beat_q == beat_t'(LINE_WORDS - 1)));

  assign wb_o.cyc = cyc_q;
  assign wb_o.stb = stb_q;
  assign wb_o.adr = adr_q;
  assign done_o   = done_q;
  assign line_o   = line_q;

  //////////////////////////////////////////////////
  // bus sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc_q    <= 1'b0;
      stb_q    <= 1'b0;
      single_q <= 1'b0;
      done_q   <= 1'b0;
      beat_q   <= '0;
      adr_q    <= '0;
    end else begin
      // done one cycle after the last ack
      done_q <= last_ack;
      if (start_i) begin
        cyc_q    <= 1'b1;
        stb_q    <= 1'b1;
        adr_q    <= addr_i;
        beat_q   <= '0;
        single_q <= single_i;
      end else if (beat_ack) begin
        // stb drops for a cycle after every ack
        stb_q <= 1'b0;
        if (last_ack) begin
          cyc_q <= 1'b0;
        end else begin
          beat_q <= beat_q + 1'b1;
          adr_q  <= adr_q + addr_t'(4);
        end
      end else if (cyc_q && !stb_q) begin
        // next beat of the line
        stb_q <= 1'b1;
      end
    end
  end

  // line beats shift in from the top, so word 0 ends low
  // a single word lands in its own slot
  always_ff @(posedge clk_i) begin
    if (beat_ack) begin
      if (single_q) begin
        line_q[adr_q[OFFSET_W-1:2]*WORD_W +: WORD_W] <= wb_i.dat;
      end else begin
        line_q <= {wb_i.dat, line_q[LINE_W-1:WORD_W]};
      end
    end
  end

endmodule

`default_nettype wire

/* icache_repl.sv */
//////////////////////////////////////////////////
// icache replacement: first invalid way or LFSR
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module icache_repl #(
  parameter int unsigned NumWays = 4
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic [NumWays-1:0] valid_i,
  input  wire logic               advance_i,
  output logic [NumWays-1:0]      victim_o
);

  localparam int unsigned WayW = $clog2(NumWays);

  typedef logic [NumWays-1:0] way_t;
  typedef logic [WayW-1:0]    way_idx_t;
  typedef logic [7:0]         lfsr_t;

  lfsr_t    lfsr_q;
  way_t     first_inv;
  way_idx_t rnd_idx;
  logic     all_valid;

  assign all_valid = &valid_i;

  // lowest-numbered invalid way, as a one-hot
  always_comb begin
    first_inv = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        first_inv = way_t'(1) << w;
      end
    end
  end

  // fold the LFSR state onto the way range
  assign rnd_idx  = way_idx_t'(lfsr_q % NumWays);
  assign victim_o = all_valid ? (way_t'(1) << rnd_idx) : first_inv;

  // x^8 + x^6 + x^5 + x^4 + 1, maximal length
  // steps only when a full set gets a new line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 8'h01;
    end else if (advance_i && all_valid) begin
      lfsr_q <= {lfsr_q[6:0], ^(lfsr_q & 8'hB8)};
    end
  end

endmodule

`default_nettype wire

/* icache_top.sv */
//////////////////////////////////////////////////
// icache top: set-associative instruction cache
// with a wishbone classic refill port
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int unsigned NumWays = 4,
  parameter int unsigned NumSets = 64
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         en_i,
  input  wire logic                         flush_i,
  // fetch port
  input  wire icache_pkg::fetch_req_t       fetch_req_i,
  output logic                              fetch_ready_o,
  output icache_pkg::fetch_rsp_t            fetch_rsp_o,
  // wishbone master
  output icache_pkg::wb_req_t               wb_o,
  output logic [icache_pkg::WORD_W/8-1:0]   wb_sel_o,
  output logic                              wb_we_o,
  input  wire icache_pkg::wb_rsp_t          wb_i
);

  import icache_pkg::*;

  localparam int unsigned IdxW = $clog2(NumSets);
  localparam int unsigned TagW = ADDR_W - IdxW - OFFSET_W;

  // config links
  logic               cache_en;
  logic               hold;
  logic               ctrl_idle;
  logic               clear;
  logic [IdxW-1:0]    clear_idx;

  // array links
  logic               rd;
  logic               wr;
  logic [IdxW-1:0]    index;
  logic [TagW-1:0]    tag;
  line_t              wr_line;
  logic               hit;
  word_t              hit_word;
  logic [NumWays-1:0] set_valid;
  logic [NumWays-1:0] victim;
  logic [NumWays-1:0] wr_way;

  // refill links
  logic               refill_start;
  addr_t              refill_addr;
  logic               refill_single;
  logic               refill_done;
  line_t              refill_line;

  // full-word reads only
  assign wb_sel_o = '1;
  assign wb_we_o  = 1'b0;

  icache_cfg #(
    .NumSets (NumSets)
  ) u_cfg (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .en_i        (en_i),
    .flush_i     (flush_i),
    .ctrl_idle_i (ctrl_idle),
    .cache_en_o  (cache_en),
    .hold_o      (hold),
    .clear_o     (clear),
    .clear_idx_o (clear_idx)
  );

  icache_ctrl #(
    .NumWays (NumWays),
    .NumSets (NumSets)
  ) u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .fetch_req_i     (fetch_req_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_rsp_o     (fetch_rsp_o),
    .cache_en_i      (cache_en),
    .hold_i          (hold),
    .idle_o          (ctrl_idle),
    .rd_o            (rd),
    .wr_o            (wr),
    .index_o         (index),
    .tag_o           (tag),
    .wr_line_o       (wr_line),
    .hit_i           (hit),
    .hit_word_i      (hit_word),
    .victim_i        (victim),
    .wr_way_o        (wr_way),
    .refill_start_o  (refill_start),
    .refill_addr_o   (refill_addr),
    .refill_single_o (refill_single),
    .refill_done_i   (refill_done),
    .refill_line_i   (refill_line)
  );

  // word offset is taken with the lookup strobe
  icache_arrays #(
    .NumWays (NumWays),
    .NumSets (NumSets)
  ) u_arrays (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_i        (rd),
    .wr_i        (wr),
    .index_i     (index),
    .tag_i       (tag),
    .wr_line_i   (wr_line),
    .wr_way_i    (wr_way),
    .offset_i    (fetch_req_i.addr[OFFSET_W-1:2]),
    .clear_i     (clear),
    .clear_idx_i (clear_idx),
    .hit_o       (hit),
    .hit_word_o  (hit_word),
    .valid_o     (set_valid)
  );

  // every allocation advances the LFSR when the set is full
  icache_repl #(
    .NumWays (NumWays)
  ) u_repl (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .valid_i   (set_valid),
    .advance_i (wr),
    .victim_o  (victim)
  );

  icache_refill u_refill (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (refill_start),
    .addr_i   (refill_addr),
    .single_i (refill_single),
    .done_o   (refill_done),
    .line_o   (refill_line),
    .wb_o     (wb_o),
    .wb_i     (wb_i)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the icache testbench with verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_icache -f icache.f -o tb_icache
./obj_dir/tb_icache

/* tb_icache.sv */
//////////////////////////////////////////////////
// icache testbench with fetch stimulus, reference
// data compare and wishbone beat counting
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  import icache_pkg::*;

  localparam int unsigned NumWays     = 4;
  localparam int unsigned NumSets     = 64;
  // lines this far apart land in the same set
  localparam int unsigned SetStride   = NumSets * 16;
  localparam int unsigned WaitLimit   = 2000;
  localparam int unsigned RandFetches = 48;
  localparam logic [31:0] Seed        = 32'h49447114;

  logic                  clk;
  logic                  rst_n;
  logic                  en;
  logic                  flush;
  fetch_req_t            fetch_req;
  logic                  fetch_ready;
  fetch_rsp_t            fetch_rsp;
  wb_req_t               wb_req;
  wb_rsp_t               wb_rsp;
  logic [WORD_W/8-1:0]   wb_sel;
  logic                  wb_we;

  integer                seed;
  // accepted fetch addresses still waiting for their response
  addr_t                 exp_q[$];
  // addresses of the acked beats of the current fetch
  addr_t                 beat_adr_q[$];
  int unsigned           beat_cnt;
  addr_t                 rsp_addr;

  icache_top #(
    .NumWays (NumWays),
    .NumSets (NumSets)
  ) dut0 (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .en_i          (en),
    .flush_i       (flush),
    .fetch_req_i   (fetch_req),
    .fetch_ready_o (fetch_ready),
    .fetch_rsp_o   (fetch_rsp),
    .wb_o          (wb_req),
    .wb_sel_o      (wb_sel),
    .wb_we_o       (wb_we),
    .wb_i          (wb_rsp)
  );

  tb_icache_mem #(
    .Seed (Seed)
  ) mem0 (
    .clk_i  (clk),
    .rst_ni (rst_n),
    .wb_i   (wb_req),
    .wb_o   (wb_rsp)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // reference and reporting
  //////////////////////////////////////////////////

  // memory rule on the word-aligned fetch address
  function automatic word_t expected_word(input addr_t addr);
    addr_t word_addr;
    word_addr = {addr[ADDR_W-1:2], 2'b00};
    return word_addr * 32'h9E3779B1 + 32'h01234567;
  endfunction

  task automatic end_with_failure;
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_error(input string what);
    $display("Error at %0t ns: %s", $time, what);
    end_with_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  // responses are checked on the falling edge
  always @(negedge clk) begin
    if (rst_n && fetch_rsp.valid) begin
      if (exp_q.size() == 0) begin
        report_error("fetch response with no request outstanding");
      end else begin
        rsp_addr = exp_q.pop_front();
        check_value("fetch_rsp_o.data", fetch_rsp.data, expected_word(rsp_addr));
      end
    end
  end

  // one beat per cycle where stb and ack meet
  always @(negedge clk) begin
    if (rst_n && wb_req.stb && wb_rsp.ack) begin
      beat_cnt = beat_cnt + 1;
      beat_adr_q.push_back(wb_req.adr);
    end
  end

  //////////////////////////////////////////////////
  // fetch helpers
  //////////////////////////////////////////////////

  task automatic wait_ready(output int unsigned cycles);
    cycles = 0;
    @(negedge clk);
    while (!fetch_ready) begin
      cycles++;
      if (cycles > WaitLimit) begin
        report_error("fetch port never became ready");
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_response;
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (!fetch_rsp.valid) begin
      waited++;
      if (waited > WaitLimit) begin
        report_error("no fetch response within the timeout");
      end
      @(negedge clk);
    end
  endtask

  // single request that returns the bus beats it cost
  task automatic fetch_word(input addr_t addr, output int unsigned beats);
    int unsigned start_cnt;
    int unsigned waited;
    beat_adr_q.delete();
    start_cnt = beat_cnt;
    @(posedge clk);
    fetch_req.req  <= 1'b1;
    fetch_req.addr <= addr;
    waited = 0;
    @(negedge clk);
    while (!fetch_ready) begin
      waited++;
      if (waited > WaitLimit) begin
        report_error("fetch request was never accepted");
      end
      @(negedge clk);
    end
    // ready and req stay put until the accepting edge
    exp_q.push_back(addr);
    @(posedge clk);
    fetch_req.req <= 1'b0;
    wait_response();
    beats = beat_cnt - start_cnt;
  endtask

  // requests on every cycle into one cached line
  task automatic hit_burst(input addr_t line_base, input int unsigned count);
    int unsigned start_cnt;
    int unsigned n;
    addr_t       addr;
    start_cnt = beat_cnt;
    for (n = 0; n < count; n++) begin
      addr = line_base + addr_t'((n % LINE_WORDS) * 4);
      @(posedge clk);
      fetch_req.req  <= 1'b1;
      fetch_req.addr <= addr;
      @(negedge clk);
      check_value("fetch_ready_o", 32'(fetch_ready), 32'd1);
      // the previous request answers in this cycle
      if (n > 0) begin
        check_value("fetch_rsp_o.valid", 32'(fetch_rsp.valid), 32'd1);
      end
      exp_q.push_back(addr);
    end
    @(posedge clk);
    fetch_req.req <= 1'b0;
    @(negedge clk);
    check_value("fetch_rsp_o.valid", 32'(fetch_rsp.valid), 32'd1);
    check_value("wb beats in hit burst", beat_cnt - start_cnt, 32'd0);
  endtask

  // a disabled cache reads one beat at the word address
  task automatic uncached_fetch(input addr_t addr);
    int unsigned beats;
    fetch_word(addr, beats);
    check_value("wb beats while disabled", beats, 32'd1);
    check_value("wb_o.adr", beat_adr_q[0], {addr[ADDR_W-1:2], 2'b00});
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int unsigned beats;
    int unsigned cycles;
    int unsigned i;
    addr_t       addr;
    addr_t       line_a;
    addr_t       set_base;
    logic [31:0] rnd;

    seed      = Seed;
    beat_cnt  = 0;
    rst_n     <= 1'b0;
    en        <= 1'b1;
    flush     <= 1'b0;
    fetch_req <= '0;

    // quiet outputs while reset is held
    @(negedge clk);
    check_value("fetch_ready_o", 32'(fetch_ready), 32'd0);
    check_value("fetch_rsp_o.valid", 32'(fetch_rsp.valid), 32'd0);
    check_value("wb_o.cyc", 32'(wb_req.cyc), 32'd0);
    check_value("wb_o.stb", 32'(wb_req.stb), 32'd0);
    check_value("wb_we_o", 32'(wb_we), 32'd0);
    check_value("wb_sel_o", 32'(wb_sel), 32'hF);
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // first miss refills the whole line and later fetches hit
    wait_ready(cycles);
    line_a = 32'h0000_1230;
    fetch_word(line_a + 32'd8, beats);
    check_value("wb beats on first miss", beats, 32'd4);
    for (i = 0; i < LINE_WORDS; i++) begin
      check_value("wb_o.adr", beat_adr_q[i], line_a + addr_t'(i * 4));
    end
    fetch_word(line_a + 32'd4, beats);
    check_value("wb beats on hit", beats, 32'd0);
    // byte offset bits are ignored
    fetch_word(line_a + 32'd13, beats);
    check_value("wb beats on hit", beats, 32'd0);

    hit_burst(line_a, 8);

    // more lines than ways in one set
    set_base = 32'h0000_2050;
    for (i = 0; i < NumWays + 2; i++) begin
      fetch_word(set_base + addr_t'(i * SetStride), beats);
      check_value("wb beats on cold miss", beats, 32'd4);
    end
    for (i = 0; i < RandFetches; i++) begin
      rnd  = $random(seed);
      addr = set_base + addr_t'((32'(rnd[7:0]) % (NumWays + 2)) * SetStride) +
             addr_t'(rnd[11:8]);
      fetch_word(addr, beats);
      if (beats != 0) begin
        check_value("wb beats on miss", beats, 32'd4);
      end
    end

    // flush drops a line that hit before
    fetch_word(line_a, beats);
    check_value("wb beats on hit", beats, 32'd0);
    @(posedge clk);
    flush <= 1'b1;
    @(negedge clk);
    check_value("fetch_ready_o", 32'(fetch_ready), 32'd0);
    @(posedge clk);
    flush <= 1'b0;
    wait_ready(cycles);
    check_value("ready low for all sets", 32'(cycles >= NumSets), 32'd1);
    fetch_word(line_a + 32'd4, beats);
    check_value("wb beats after flush", beats, 32'd4);
    fetch_word(line_a + 32'd8, beats);
    check_value("wb beats on hit", beats, 32'd0);

    // with the cache disabled every fetch goes to the bus
    @(posedge clk);
    en <= 1'b0;
    uncached_fetch(line_a + 32'd8);
    uncached_fetch(line_a + 32'd8);
    uncached_fetch(set_base + 32'd6);
    for (i = 0; i < 4; i++) begin
      rnd = $random(seed);
      uncached_fetch(rnd);
    end

    @(negedge clk);
    check_value("outstanding fetches", exp_q.size(), 32'd0);
    check_value("wb_o.cyc", 32'(wb_req.cyc), 32'd0);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_icache_mem.sv */
//////////////////////////////////////////////////
// wishbone classic slave model with random wait
// states and address-derived read data
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_icache_mem #(
  parameter logic [31:0] Seed = 32'h0
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire icache_pkg::wb_req_t wb_i,
  output icache_pkg::wb_rsp_t      wb_o
);

  import icache_pkg::*;

  integer     seed;
  logic       ack_q;
  word_t      dat_q;
  // a beat has been seen and its wait states are counting
  logic       armed_q;
  logic [1:0] wait_q;

  initial seed = Seed;

  assign wb_o.ack = ack_q;
  assign wb_o.dat = dat_q;

  // memory content: word address times a golden-ratio constant plus an offset
  function automatic word_t data_at(input addr_t adr);
    addr_t word_adr;
    word_adr = {adr[ADDR_W-1:2], 2'b00};
    return word_adr * 32'h9E3779B1 + 32'h01234567;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin : beat_seq
    logic [31:0] rnd;
    if (!rst_ni) begin
      ack_q   <= 1'b0;
      dat_q   <= '0;
      armed_q <= 1'b0;
      wait_q  <= '0;
    end else if (ack_q) begin
      // master takes the ack on this edge and drops stb
      ack_q <= 1'b0;
    end else if (wb_i.cyc && wb_i.stb) begin
      if (!armed_q) begin
        // new beat, draw 0 to 3 wait states
        rnd = $random(seed);
        if (rnd[1:0] == 2'd0) begin
          ack_q <= 1'b1;
          dat_q <= data_at(wb_i.adr);
        end else begin
          armed_q <= 1'b1;
          wait_q  <= rnd[1:0] - 2'd1;
        end
      end else if (wait_q == 2'd0) begin
        ack_q   <= 1'b1;
        dat_q   <= data_at(wb_i.adr);
        armed_q <= 1'b0;
      end else begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire
